// ==== compile.f ====
+incdir+.
tree_pkg.sv
stream_pkg.sv
tree_store.sv
tree_walker.sv
header_synth.sv
bit_packer.sv
header_top.sv
header_checker.sv
header_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f compile.f --top-module header_tb -o header_sim

out=$(./obj_dir/header_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED"

// ==== header_tb.sv ====
`timescale 1ns/1ps
`include "header_cfg.svh"

module header_tb import tree_pkg::*, stream_pkg::*; ();
    localparam int NUM_RANDOM  = 8;
    // two-leaf, deep, random, and the reload pair
    localparam int TOTAL_NODES = 3 + 61 + NUM_RANDOM * 63 + 63 + 3;
    localparam int WATCHDOG_NS = TOTAL_NODES * 400 + 20000;

    typedef struct packed {
        node_idx_t               node;
        logic [1:0]              stage;     // next step: 0 left child, 1 right child, 2 backtrack
        logic                    is_left;
        logic [`HDR_LEFTS_W-1:0] lefts;
    } ref_frame_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        node_valid;
    logic        node_ready;
    node_word_t  node_data;
    logic        start;
    logic        busy;
    logic        out_valid;
    logic        out_ready;
    hdr_byte_t   out_byte;

    node_word_t  tree [`HDR_MAX_NODES];   // testbench copy of the loaded tree
    int          n_nodes;
    int          errors;
    logic [31:0] seed = 32'h4b59;
    logic        exp_bits [$];            // expected header, one entry per bit

    header_top uut (
        .clk(clk), .rst(rst), .node_valid(node_valid), .node_ready(node_ready),
        .node_data(node_data), .start(start), .busy(busy), .out_valid(out_valid),
        .out_ready(out_ready), .out_byte(out_byte)
    );

    always #4 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out, the DUT stopped making progress");
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic set_leaf(input int idx, input int ch);
        node_word_t w;
        w              = '0;
        w.leaf.is_leaf = 1'b1;
        w.leaf.ch      = 8'(ch);
        tree[node_idx_t'(idx)] = w;
    endtask

    task automatic set_inner(input int idx, input int left, input int right);
        node_word_t w;
        w.inner.is_leaf = 1'b0;
        w.inner.left    = node_idx_t'(left);
        w.inner.right   = node_idx_t'(right);
        tree[node_idx_t'(idx)] = w;
    endtask

    task automatic build_two_leaf(input int left_ch, input int right_ch);
        set_inner(0, 1, 2);
        set_leaf(1, left_ch);
        set_leaf(2, right_ch);
        n_nodes = 3;
    endtask

    // left spine whose right children each hold a leaf pair, so left counts climb with depth
    task automatic build_deep();
        for (int i = 0; i < 15; i++) begin
            set_inner(4 * i, 4 * i + 4, 4 * i + 1);
            set_inner(4 * i + 1, 4 * i + 2, 4 * i + 3);
            set_leaf(4 * i + 2, 8'h30 + i);
            set_leaf(4 * i + 3, 8'hb0 + i);
        end
        set_leaf(60, 8'hff);
        n_nodes = 61;
    endtask

    task automatic build_random(input int leaves);
        int pend_idx [$];
        int pend_cnt [$];
        int idx;
        int cnt;
        int split;
        pend_idx.push_back(0);
        pend_cnt.push_back(leaves);
        n_nodes = 1;
        while (pend_idx.size() > 0) begin
            idx = pend_idx.pop_back();
            cnt = pend_cnt.pop_back();
            if (cnt == 1) begin
                set_leaf(idx, int'(next_rand() >> 24));
            end else begin
                split = 1 + int'((next_rand() >> 16) % 32'(cnt - 1));   // leaves on the left
                set_inner(idx, n_nodes, n_nodes + 1);
                pend_idx.push_back(n_nodes);
                pend_cnt.push_back(split);
                pend_idx.push_back(n_nodes + 1);
                pend_cnt.push_back(cnt - split);
                n_nodes += 2;
            end
        end
    endtask

    task automatic push_field(input logic [7:0] value);
        exp_bits.push_back(1'b1);   // every field opens with a 1
        repeat (8) begin
            exp_bits.push_back(value[7]);
            value = {value[6:0], 1'b0};
        end
    endtask

    task automatic model_walk();
        ref_frame_t stack [$];
        ref_frame_t f;
        ref_frame_t child;
        node_word_t w;
        exp_bits.delete();
        stack.push_back('0);
        while (stack.size() > 0) begin
            f = stack.pop_back();
            w = tree[f.node];
            if (f.stage == 2'd0 && w.leaf.is_leaf) begin
                push_field(w.leaf.ch);
                if (f.is_left) push_field(f.lefts);
            end else if (f.stage == 2'd2) begin
                exp_bits.push_back(1'b0);   // back from a right subtree
            end else begin
                child.node    = (f.stage == 2'd0) ? w.inner.left : w.inner.right;
                child.stage   = 2'd0;
                child.is_left = (f.stage == 2'd0);
                child.lefts   = f.lefts + 8'(child.is_left);
                f.stage       = f.stage + 2'd1;
                stack.push_back(f);
                stack.push_back(child);
            end
        end
    endtask

    task automatic check_reset_state();
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        check_value(32'(busy), 32'd0, "busy after reset");
        check_value(32'(node_ready), 32'd1, "node_ready after reset");
    endtask

    task automatic run_tree(input string name, input logic stall);
        hdr_byte_t   got [$];
        logic [31:0] r;
        logic [7:0]  exp_byte;
        logic        done;
        int          nbytes;
        int          k;
        model_walk();
        nbytes = (exp_bits.size() + 7) / 8;
        for (int i = 0; i < n_nodes; i++) begin
            node_valid = 1'b1;
            node_data  = tree[node_idx_t'(i)];
            while (!node_ready) @(negedge clk);
            @(negedge clk);   // word taken on the rising edge in between
        end
        node_valid = 1'b0;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value(32'(busy), 32'd1, {name, ": busy after start"});
        done = 1'b0;
        while (!done) begin
            r         = next_rand();
            out_ready = !stall || r[20];
            if (out_valid && out_ready) begin
                got.push_back(out_byte);
                done = out_byte.last;
            end
            @(negedge clk);
        end
        out_ready = 1'b1;
        check_value(32'(busy), 32'd0, {name, ": busy after the last byte"});
        check_value(got.size(), nbytes, {name, ": byte count"});
        k = 0;
        for (int i = 0; i < nbytes && i < got.size(); i++) begin
            repeat (8) begin
                exp_byte = {exp_byte[6:0], (k < exp_bits.size()) ? exp_bits[k] : 1'b0};
                k++;
            end
            check_value(32'(got[i].data), 32'(exp_byte), $sformatf("%s: byte %0d", name, i));
            check_value(32'(got[i].last), 32'(i == nbytes - 1),
                        $sformatf("%s: last flag of byte %0d", name, i));
        end
    endtask

    initial begin
        errors     = 0;
        rst        = 1'b1;
        node_valid = 1'b0;
        node_data  = '0;
        start      = 1'b0;
        out_ready  = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        build_two_leaf(8'h41, 8'h5a);
        run_tree("two leaf", 1'b0);
        build_deep();
        run_tree("deep", 1'b0);
        for (int t = 0; t < NUM_RANDOM; t++) begin
            build_random(1 + int'((next_rand() >> 16) % 32'd32));
            run_tree($sformatf("random %0d", t), t[0]);
        end
        // a small tree right after a full one must land at address 0 again
        build_random(32);
        run_tree("full tree before reload", 1'b1);
        build_two_leaf(8'hc3, 8'h07);
        run_tree("tree after reload", 1'b1);
        $display("all tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== header_checker.sv ====
`timescale 1ns/1ps

module header_checker import stream_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      busy,
    input logic      ev_valid,
    input logic      ev_ready,
    input logic      bit_valid,
    input logic      bit_ready,
    input hdr_bit_t  bit_data,
    input logic      out_valid,
    input logic      out_ready,
    input hdr_byte_t out_byte
);

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_byte))
        else $error("output byte dropped or changed before it was accepted");

    assert property (@(posedge clk) disable iff (rst)
        bit_valid && !bit_ready |=> bit_valid && $stable(bit_data))
        else $error("header bit dropped or changed before it was accepted");

    assert property (@(posedge clk) disable iff (rst) ev_valid && !ev_ready |=> ev_valid)
        else $error("walker event withdrawn before it was accepted");

    // an idle subsystem has no event or header bit in flight
    assert property (@(posedge clk) disable iff (rst) !busy |-> !ev_valid && !bit_valid)
        else $error("event or header bit pending while busy is low");

    assert property (@(posedge clk)
        rst && $past(rst) |-> !out_valid && !busy && !ev_valid && !bit_valid)
        else $error("valid or busy high during reset");

endmodule

bind header_top header_checker chk (
    .clk(clk), .rst(rst), .busy(busy), .ev_valid(ev_valid), .ev_ready(ev_ready),
    .bit_valid(bit_valid), .bit_ready(bit_ready), .bit_data(bit_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_byte(out_byte)
);

// ==== header_top.sv ====
`timescale 1ns/1ps

module header_top import tree_pkg::*, stream_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       node_valid,
    output logic       node_ready,
    input  node_word_t node_data,
    input  logic       start,
    output logic       busy,
    output logic       out_valid,
    input  logic       out_ready,
    output hdr_byte_t  out_byte
);
    logic        store_ready;
    logic        store_wr_valid;
    logic        walk_busy;
    logic        walk_start;
    logic        clear;
    node_idx_t   rd_addr;
    node_word_t  rd_data;
    logic        ev_valid;
    logic        ev_ready;
    tree_event_t ev;
    logic        bit_valid;
    logic        bit_ready;
    hdr_bit_t    bit_data;

    // the final byte can still be waiting after the walker goes idle
    assign busy           = walk_busy | out_valid;
    assign node_ready     = store_ready & ~busy;
    assign store_wr_valid = node_valid & ~busy;
    assign walk_start     = start & ~busy;

    tree_store u_store (
        .clk(clk), .rst(rst), .wr_valid(store_wr_valid), .wr_ready(store_ready),
        .wr_data(node_data), .clear(clear), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    tree_walker u_walker (
        .clk(clk), .rst(rst), .start(walk_start), .busy(walk_busy), .rd_addr(rd_addr),
        .rd_data(rd_data), .ev_valid(ev_valid), .ev_ready(ev_ready), .ev(ev), .clear(clear)
    );

    header_synth u_synth (
        .clk(clk), .rst(rst), .ev_valid(ev_valid), .ev_ready(ev_ready), .ev(ev),
        .bit_valid(bit_valid), .bit_ready(bit_ready), .bit_data(bit_data)
    );

    bit_packer u_packer (
        .clk(clk), .rst(rst), .bit_valid(bit_valid), .bit_ready(bit_ready),
        .bit_data(bit_data), .out_valid(out_valid), .out_ready(out_ready), .out_byte(out_byte)
    );

endmodule

// ==== bit_packer.sv ====
`timescale 1ns/1ps

module bit_packer import stream_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      bit_valid,
    output logic      bit_ready,
    input  hdr_bit_t  bit_data,
    output logic      out_valid,
    input  logic      out_ready,
    output hdr_byte_t out_byte
);
    logic [6:0] acc;      // collected bits, newest in the lsb
    logic [2:0] cnt;      // bits already held in acc
    logic [7:0] merged;
    logic       xfer;
    logic       full;

    assign bit_ready = !out_valid || out_ready;   // held off while a byte waits
    assign xfer      = bit_valid && bit_ready;
    assign full      = (cnt == 3'd7) || bit_data.last;
    // left align so the earliest bit lands in the msb and the tail is zero
    assign merged    = {acc, bit_data.value} << (3'd7 - cnt);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            cnt       <= '0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (xfer) begin
                if (full) begin
                    out_valid <= 1'b1;
                    cnt       <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            acc <= {acc[5:0], bit_data.value};
            if (full) begin
                out_byte <= '{data: merged, last: bit_data.last};
            end
        end
    end

endmodule

// ==== header_synth.sv ====
`timescale 1ns/1ps
`include "header_cfg.svh"

module header_synth import tree_pkg::*, stream_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ev_valid,
    output logic        ev_ready,
    input  tree_event_t ev,
    output logic        bit_valid,
    input  logic        bit_ready,
    output hdr_bit_t    bit_data
);
    localparam int SH_W  = `HDR_CHAR_W + 1;
    localparam int CNT_W = $clog2(SH_W + 1);

    logic             active;
    logic             lefts_phase;   // shifting the left count of a left leaf
    logic [SH_W-1:0]  shreg;
    logic [CNT_W-1:0] remain;        // bits left in the current segment
    logic             seg_end;
    logic             final_bit;
    logic             xfer;

    assign xfer      = bit_valid && bit_ready;
    assign seg_end   = (remain == CNT_W'(1));
    assign final_bit = seg_end && (ev.kind == back_ev || !ev.is_left || lefts_phase);

    assign bit_valid      = active;
    assign bit_data.value = shreg[SH_W-1];   // msb first
    assign bit_data.last  = final_bit && ev.last;
    assign ev_ready       = xfer && final_bit;   // event retires with its final bit

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            lefts_phase <= 1'b0;
            remain      <= '0;
        end else if (!active) begin
            if (ev_valid) begin
                active      <= 1'b1;
                lefts_phase <= 1'b0;
                remain      <= (ev.kind == leaf_ev) ? CNT_W'(SH_W) : CNT_W'(1);
            end
        end else if (xfer) begin
            if (final_bit) begin
                active <= 1'b0;
            end else if (seg_end) begin
                lefts_phase <= 1'b1;   // character done, the left count follows
                remain      <= CNT_W'(SH_W);
            end else begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && ev_valid) begin
            // a back event is a single 0 taken from the cleared msb
            shreg <= (ev.kind == leaf_ev) ? {1'b1, ev.ch} : '0;
        end else if (xfer) begin
            if (seg_end) begin
                shreg <= {1'b1, ev.lefts};
            end else begin
                shreg <= {shreg[SH_W-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== tree_walker.sv ====
`timescale 1ns/1ps
`include "header_cfg.svh"

module tree_walker import tree_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        busy,
    output node_idx_t   rd_addr,
    input  node_word_t  rd_data,
    output logic        ev_valid,
    input  logic        ev_ready,
    output tree_event_t ev,
    output logic        clear
);
    localparam int SP_W = $clog2(`HDR_STACK_DEPTH) + 1;

    typedef struct packed {
        node_idx_t               next_idx;   // right child, visited once the left side is done
        logic                    right_side; // set while the right subtree is being walked
        logic [`HDR_LEFTS_W-1:0] lefts;      // left edges from the root to this node
    } frame_t;

    typedef enum logic [2:0] {st_idle, st_fetch, st_visit, st_emit, st_return} state_t;

    state_t                  state;
    frame_t                  stack [`HDR_STACK_DEPTH];
    logic [SP_W-1:0]         sp;
    logic [SP_W-1:0]         top_ptr;
    frame_t                  top;
    node_idx_t               cur;
    logic                    cur_left;
    logic [`HDR_LEFTS_W-1:0] cur_lefts;
    logic                    is_leaf;

    assign rd_addr = cur;
    assign top_ptr = sp - 1'b1;
    assign top     = stack[top_ptr[SP_W-2:0]];
    assign is_leaf = rd_data.leaf.is_leaf;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            sp        <= '0;
            cur       <= '0;
            cur_left  <= 1'b0;
            cur_lefts <= '0;
            busy      <= 1'b0;
            ev_valid  <= 1'b0;
            clear     <= 1'b0;
        end else begin
            clear <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        busy      <= 1'b1;
                        sp        <= '0;
                        cur       <= '0;   // node 0 is the root
                        cur_left  <= 1'b0;
                        cur_lefts <= '0;
                        state     <= st_fetch;
                    end
                end
                st_fetch: state <= st_visit;   // address out, node word back next cycle
                st_visit: begin
                    if (is_leaf) begin
                        ev_valid <= 1'b1;
                        state    <= st_emit;
                    end else begin
                        sp        <= sp + 1'b1;   // push and descend left
                        cur       <= rd_data.inner.left;
                        cur_left  <= 1'b1;
                        cur_lefts <= cur_lefts + 1'b1;
                        state     <= st_fetch;
                    end
                end
                st_emit: begin
                    if (ev_ready) begin
                        ev_valid <= 1'b0;
                        if (ev.last) begin
                            busy  <= 1'b0;
                            clear <= 1'b1;   // lets the host load the next tree
                            state <= st_idle;
                        end else begin
                            state <= st_return;
                        end
                    end
                end
                st_return: begin
                    if (!top.right_side) begin
                        cur       <= top.next_idx;
                        cur_left  <= 1'b0;
                        cur_lefts <= top.lefts;
                        state     <= st_fetch;
                    end else begin
                        sp       <= sp - 1'b1;   // right subtree finished, backtrack
                        ev_valid <= 1'b1;
                        state    <= st_emit;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_visit) begin
            if (is_leaf) begin
                ev <= '{kind: leaf_ev, ch: rd_data.leaf.ch, is_left: cur_left,
                        lefts: cur_lefts, last: (sp == '0)};
            end else begin
                stack[sp[SP_W-2:0]] <= '{next_idx: rd_data.inner.right, right_side: 1'b0,
                                         lefts: cur_lefts};
            end
        end
        if (state == st_return) begin
            if (!top.right_side) begin
                stack[top_ptr[SP_W-2:0]].right_side <= 1'b1;
            end else begin
                ev <= '{kind: back_ev, ch: '0, is_left: 1'b0, lefts: '0,
                        last: (sp == SP_W'(1))};   // popping the root ends the walk
            end
        end
    end

endmodule

// ==== tree_store.sv ====
`timescale 1ns/1ps
`include "header_cfg.svh"

module tree_store import tree_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  node_word_t wr_data,
    input  logic       clear,
    input  node_idx_t  rd_addr,
    output node_word_t rd_data
);
    localparam int PTR_W = $clog2(`HDR_MAX_NODES) + 1;

    node_word_t       mem [`HDR_MAX_NODES];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] ptr_next;
    logic             wr_fire;

    assign wr_fire = wr_valid && wr_ready;

    always_comb begin
        ptr_next = wr_ptr;
        if (clear) begin
            ptr_next = '0;   // next load starts over at the root
        end else if (wr_fire) begin
            ptr_next = wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            wr_ready <= 1'b0;
        end else begin
            wr_ptr   <= ptr_next;
            wr_ready <= (ptr_next != PTR_W'(`HDR_MAX_NODES));   // stop once the memory is full
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[`HDR_IDX_W-1:0]] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // one cycle read latency
    end

endmodule

// ==== stream_pkg.sv ====
package stream_pkg;

    // one header bit on its way to the packer
    typedef struct packed {
        logic value;
        logic last;   // final bit of the whole header
    } hdr_bit_t;

    // one output byte, msb was the earliest header bit
    typedef struct packed {
        logic [7:0] data;
        logic       last;   // final byte, zero padded
    } hdr_byte_t;

endpackage

// ==== tree_pkg.sv ====
`include "header_cfg.svh"

package tree_pkg;

    typedef logic [`HDR_IDX_W-1:0] node_idx_t;

    typedef struct packed {
        logic                                  is_leaf; // tag bit, 1 for a leaf
        logic [2*`HDR_IDX_W-`HDR_CHAR_W-1:0]   pad;
        logic [`HDR_CHAR_W-1:0]                ch;
    } leaf_word_t;

    typedef struct packed {
        logic      is_leaf; // tag bit, 0 for an internal node
        node_idx_t left;
        node_idx_t right;
    } inner_word_t;

    // the same 13-bit word read either as a leaf or as an internal node
    typedef union packed {
        leaf_word_t  leaf;
        inner_word_t inner;
    } node_word_t;

    typedef enum bit {leaf_ev, back_ev} ev_kind_t;

    typedef struct packed {
        ev_kind_t                kind;
        logic [`HDR_CHAR_W-1:0]  ch;
        logic                    is_left;
        logic [`HDR_LEFTS_W-1:0] lefts;
        logic                    last;   // final event of the walk
    } tree_event_t;

endpackage

// ==== header_cfg.svh ====
`ifndef HEADER_CFG_SVH
`define HEADER_CFG_SVH

// tree capacity, also the depth of the node memory
`define HDR_MAX_NODES 64

// node address width, enough to index every node
`define HDR_IDX_W 6

// character index carried by a leaf
`define HDR_CHAR_W 8

// number of left edges from the root to a leaf
`define HDR_LEFTS_W 8

// walker stack, one frame per internal node on the current path
`define HDR_STACK_DEPTH 32

`endif
